// File: Bender.yml
package:
  name: mini_soc

sources:
  - common/soc_pkg.sv
  - hw/bus_arbiter.sv
  - hw/periph_mux.sv
  - hw/debug_req_gate.sv
  - mem/boot_rom.sv
  - mem/data_sram.sv
  - hw/soc_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_soc_top.sv

// File: common/soc_pkg.sv
// Shared address map, bus widths and enum types, referenced by scoped names from all RTL files
package soc_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  // Boot ROM, 16 words of 64 bits
  localparam logic [AddrWidth-1:0] RomBase   = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength = 32'h0000_0080;
  localparam int unsigned          RomWords  = 16;

  // Upper half of every ROM word, the lower half carries the word index
  localparam logic [31:0] RomTag = 32'h600d_b007;

  // Data SRAM, its length comes from the SramWords parameter of the top level
  localparam logic [AddrWidth-1:0] SramBase = 32'h8000_0000;

  // Exit register inside the SRAM, word index 128
  localparam logic [AddrWidth-1:0] ExitOffset = 32'h0000_0400;

  // ----------------------------------------
  // Enums
  // ----------------------------------------
  // Decoded bus target
  typedef enum logic [1:0] {
    SEL_ROM,
    SEL_SRAM,
    SEL_ERR
  } slave_e;

  // Owner of the shared bus
  typedef enum logic {
    MST_CORE,
    MST_DEBUG
  } master_e;

endpackage

// File: hw/bus_arbiter.sv
// Round-robin arbiter for the core and debug masters, returns each response to its owner
module bus_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Core master
  input  logic                          core_req_i,
  input  logic                          core_we_i,
  input  logic [soc_pkg::AddrWidth-1:0] core_addr_i,
  input  logic [soc_pkg::DataWidth-1:0] core_wdata_i,
  input  logic [soc_pkg::BeWidth-1:0]   core_be_i,
  output logic                          core_gnt_o,
  output logic                          core_rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] core_rdata_o,
  output logic                          core_err_o,
  // Debug module master
  input  logic                          dbg_req_i,
  input  logic                          dbg_we_i,
  input  logic [soc_pkg::AddrWidth-1:0] dbg_addr_i,
  input  logic [soc_pkg::DataWidth-1:0] dbg_wdata_i,
  input  logic [soc_pkg::BeWidth-1:0]   dbg_be_i,
  output logic                          dbg_gnt_o,
  output logic                          dbg_rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] dbg_rdata_o,
  output logic                          dbg_err_o,
  // Shared bus
  output logic                          bus_req_o,
  output logic                          bus_we_o,
  output logic [soc_pkg::AddrWidth-1:0] bus_addr_o,
  output logic [soc_pkg::DataWidth-1:0] bus_wdata_o,
  output logic [soc_pkg::BeWidth-1:0]   bus_be_o,
  input  logic [soc_pkg::DataWidth-1:0] bus_rdata_i,
  input  logic                          bus_err_i
);

  soc_pkg::master_e winner;
  soc_pkg::master_e last_q;
  soc_pkg::master_e rsp_owner_q;
  logic             rsp_valid_q;

  // On a tie the master that lost last time wins
  always_comb begin
    if (core_req_i && dbg_req_i) begin
      if (last_q == soc_pkg::MST_CORE) begin
        winner = soc_pkg::MST_DEBUG;
      end else begin
        winner = soc_pkg::MST_CORE;
      end
    end else if (dbg_req_i) begin
      winner = soc_pkg::MST_DEBUG;
    end else begin
      winner = soc_pkg::MST_CORE;
    end
  end

  assign core_gnt_o = core_req_i & (winner == soc_pkg::MST_CORE);
  assign dbg_gnt_o  = dbg_req_i & (winner == soc_pkg::MST_DEBUG);

  // Forward the winner's request fields
  assign bus_req_o   = core_req_i | dbg_req_i;
  assign bus_we_o    = (winner == soc_pkg::MST_DEBUG) ? dbg_we_i : core_we_i;
  assign bus_addr_o  = (winner == soc_pkg::MST_DEBUG) ? dbg_addr_i : core_addr_i;
  assign bus_wdata_o = (winner == soc_pkg::MST_DEBUG) ? dbg_wdata_i : core_wdata_i;
  assign bus_be_o    = (winner == soc_pkg::MST_DEBUG) ? dbg_be_i : core_be_i;

  // Debug counts as last owner so the core goes first after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q      <= soc_pkg::MST_DEBUG;
      rsp_owner_q <= soc_pkg::MST_CORE;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= bus_req_o;
      if (bus_req_o) begin
        last_q      <= winner;
        rsp_owner_q <= winner;
      end
    end
  end

  // Response goes back to the granted master only
  assign core_rvalid_o = rsp_valid_q & (rsp_owner_q == soc_pkg::MST_CORE);
  assign dbg_rvalid_o  = rsp_valid_q & (rsp_owner_q == soc_pkg::MST_DEBUG);
  assign core_rdata_o  = core_rvalid_o ? bus_rdata_i : '0;
  assign dbg_rdata_o   = dbg_rvalid_o ? bus_rdata_i : '0;
  assign core_err_o    = core_rvalid_o & bus_err_i;
  assign dbg_err_o     = dbg_rvalid_o & bus_err_i;

endmodule

// File: hw/debug_req_gate.sv
// Holds off debug requests for a fixed time after reset and passes them only while enabled
module debug_req_gate #(
  parameter int unsigned DebugDelay = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = (DebugDelay > 0) ? $clog2(DebugDelay + 1) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                cnt_done;

  assign cnt_done = (cnt_q == '0);

  // ----------------------------------------
  // Post-reset delay
  // ----------------------------------------
  // Counts down once and then sticks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DebugDelay);
    end else if (!cnt_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // ----------------------------------------
  // Gate
  // ----------------------------------------
  // Combinational path from the request so disabling takes effect at once
  assign debug_req_o = cnt_done & debug_en_i & debug_req_i;

endmodule

// File: hw/periph_mux.sv
// Address decoder between the shared bus and ROM, SRAM and the error responder
module periph_mux #(
  parameter int unsigned SramWords = 256
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Shared bus
  input  logic                           bus_req_i,
  input  logic                           bus_we_i,
  input  logic [soc_pkg::AddrWidth-1:0]  bus_addr_i,
  input  logic [soc_pkg::DataWidth-1:0]  bus_wdata_i,
  input  logic [soc_pkg::BeWidth-1:0]    bus_be_i,
  output logic [soc_pkg::DataWidth-1:0]  bus_rdata_o,
  output logic                           bus_err_o,
  // Boot ROM
  output logic                           rom_req_o,
  output logic [$clog2(soc_pkg::RomWords)-1:0] rom_idx_o,
  input  logic [soc_pkg::DataWidth-1:0]  rom_rdata_i,
  // Data SRAM
  output logic                           sram_req_o,
  output logic                           sram_we_o,
  output logic [$clog2(SramWords)-1:0]   sram_idx_o,
  output logic [soc_pkg::DataWidth-1:0]  sram_wdata_o,
  output logic [soc_pkg::BeWidth-1:0]    sram_be_o,
  input  logic [soc_pkg::DataWidth-1:0]  sram_rdata_i
);

  localparam int unsigned ByteBits    = $clog2(soc_pkg::BeWidth);
  localparam int unsigned RomIdxWidth = $clog2(soc_pkg::RomWords);
  localparam int unsigned SramIdxWidth = $clog2(SramWords);
  localparam logic [soc_pkg::AddrWidth-1:0] SramLength =
      soc_pkg::AddrWidth'(SramWords * soc_pkg::BeWidth);

  logic [soc_pkg::AddrWidth-1:0] rom_off;
  logic [soc_pkg::AddrWidth-1:0] sram_off;
  soc_pkg::slave_e               sel_d;
  soc_pkg::slave_e               sel_q;
  logic                          we_q;

  assign rom_off  = bus_addr_i - soc_pkg::RomBase;
  assign sram_off = bus_addr_i - soc_pkg::SramBase;

  // ROM is read-only, writes there go to the error responder
  always_comb begin
    if (bus_addr_i >= soc_pkg::RomBase && rom_off < soc_pkg::RomLength && !bus_we_i) begin
      sel_d = soc_pkg::SEL_ROM;
    end else if (bus_addr_i >= soc_pkg::SramBase && sram_off < SramLength) begin
      sel_d = soc_pkg::SEL_SRAM;
    end else begin
      sel_d = soc_pkg::SEL_ERR;
    end
  end

  assign rom_req_o    = bus_req_i & (sel_d == soc_pkg::SEL_ROM);
  assign rom_idx_o    = rom_off[ByteBits +: RomIdxWidth];
  assign sram_req_o   = bus_req_i & (sel_d == soc_pkg::SEL_SRAM);
  assign sram_we_o    = bus_we_i;
  assign sram_idx_o   = sram_off[ByteBits +: SramIdxWidth];
  assign sram_wdata_o = bus_wdata_i;
  assign sram_be_o    = bus_be_i;

  // Selection of the request now being answered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= soc_pkg::SEL_ROM;
      we_q  <= 1'b0;
    end else if (bus_req_i) begin
      sel_q <= sel_d;
      we_q  <= bus_we_i;
    end
  end

  // Writes and errors answer with zero data
  always_comb begin
    bus_rdata_o = '0;
    if (!we_q) begin
      case (sel_q)
        soc_pkg::SEL_ROM:  bus_rdata_o = rom_rdata_i;
        soc_pkg::SEL_SRAM: bus_rdata_o = sram_rdata_i;
        default:           bus_rdata_o = '0;
      endcase
    end
  end

  assign bus_err_o = (sel_q == soc_pkg::SEL_ERR);

endmodule

// File: hw/soc_top.sv
// Top level of the shared-bus system, instantiate with the core and debug master ports driven
module soc_top #(
  parameter int unsigned SramWords  = 256,
  parameter int unsigned DebugDelay = 500
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Core master
  input  logic                          core_req_i,
  input  logic                          core_we_i,
  input  logic [soc_pkg::AddrWidth-1:0] core_addr_i,
  input  logic [soc_pkg::DataWidth-1:0] core_wdata_i,
  input  logic [soc_pkg::BeWidth-1:0]   core_be_i,
  output logic                          core_gnt_o,
  output logic                          core_rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] core_rdata_o,
  output logic                          core_err_o,
  // Debug module master
  input  logic                          dbg_req_i,
  input  logic                          dbg_we_i,
  input  logic [soc_pkg::AddrWidth-1:0] dbg_addr_i,
  input  logic [soc_pkg::DataWidth-1:0] dbg_wdata_i,
  input  logic [soc_pkg::BeWidth-1:0]   dbg_be_i,
  output logic                          dbg_gnt_o,
  output logic                          dbg_rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] dbg_rdata_o,
  output logic                          dbg_err_o,
  // Debug request towards the core
  input  logic                          debug_req_i,
  input  logic                          debug_en_i,
  output logic                          debug_req_o,
  output logic [31:0]                   exit_o
);

  // Shared bus
  logic                          bus_req;
  logic                          bus_we;
  logic [soc_pkg::AddrWidth-1:0] bus_addr;
  logic [soc_pkg::DataWidth-1:0] bus_wdata;
  logic [soc_pkg::BeWidth-1:0]   bus_be;
  logic [soc_pkg::DataWidth-1:0] bus_rdata;
  logic                          bus_err;

  // Targets
  logic                                rom_req;
  logic [$clog2(soc_pkg::RomWords)-1:0] rom_idx;
  logic [soc_pkg::DataWidth-1:0]       rom_rdata;
  logic                                sram_req;
  logic                                sram_we;
  logic [$clog2(SramWords)-1:0]        sram_idx;
  logic [soc_pkg::DataWidth-1:0]       sram_wdata;
  logic [soc_pkg::BeWidth-1:0]         sram_be;
  logic [soc_pkg::DataWidth-1:0]       sram_rdata;

  // ----------------------------------------
  // Arbitration and decode
  // ----------------------------------------
  bus_arbiter i_bus_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .core_req_i    ( core_req_i    ),
    .core_we_i     ( core_we_i     ),
    .core_addr_i   ( core_addr_i   ),
    .core_wdata_i  ( core_wdata_i  ),
    .core_be_i     ( core_be_i     ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rdata_o  ( core_rdata_o  ),
    .core_err_o    ( core_err_o    ),
    .dbg_req_i     ( dbg_req_i     ),
    .dbg_we_i      ( dbg_we_i      ),
    .dbg_addr_i    ( dbg_addr_i    ),
    .dbg_wdata_i   ( dbg_wdata_i   ),
    .dbg_be_i      ( dbg_be_i      ),
    .dbg_gnt_o     ( dbg_gnt_o     ),
    .dbg_rvalid_o  ( dbg_rvalid_o  ),
    .dbg_rdata_o   ( dbg_rdata_o   ),
    .dbg_err_o     ( dbg_err_o     ),
    .bus_req_o     ( bus_req       ),
    .bus_we_o      ( bus_we        ),
    .bus_addr_o    ( bus_addr      ),
    .bus_wdata_o   ( bus_wdata     ),
    .bus_be_o      ( bus_be        ),
    .bus_rdata_i   ( bus_rdata     ),
    .bus_err_i     ( bus_err       )
  );

  periph_mux #(
    .SramWords ( SramWords )
  ) i_periph_mux (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .bus_req_i    ( bus_req    ),
    .bus_we_i     ( bus_we     ),
    .bus_addr_i   ( bus_addr   ),
    .bus_wdata_i  ( bus_wdata  ),
    .bus_be_i     ( bus_be     ),
    .bus_rdata_o  ( bus_rdata  ),
    .bus_err_o    ( bus_err    ),
    .rom_req_o    ( rom_req    ),
    .rom_idx_o    ( rom_idx    ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_req_o   ( sram_req   ),
    .sram_we_o    ( sram_we    ),
    .sram_idx_o   ( sram_idx   ),
    .sram_wdata_o ( sram_wdata ),
    .sram_be_o    ( sram_be    ),
    .sram_rdata_i ( sram_rdata )
  );

  // ----------------------------------------
  // Memories
  // ----------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  data_sram #(
    .SramWords ( SramWords )
  ) i_data_sram (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .idx_i   ( sram_idx   ),
    .wdata_i ( sram_wdata ),
    .be_i    ( sram_be    ),
    .rdata_o ( sram_rdata ),
    .exit_o  ( exit_o     )
  );

  // Debug request hold-off
  debug_req_gate #(
    .DebugDelay ( DebugDelay )
  ) i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: mem/boot_rom.sv
// Boot ROM with content given by a fixed rule, read one cycle after the request
module boot_rom (
  input  logic                                 clk_i,
  input  logic                                 req_i,
  input  logic [$clog2(soc_pkg::RomWords)-1:0] idx_i,
  output logic [soc_pkg::DataWidth-1:0]        rdata_o
);

  localparam int unsigned IdxWidth = $clog2(soc_pkg::RomWords);

  // Tag in the upper half, word index in the lower half
  function automatic logic [soc_pkg::DataWidth-1:0] rom_word(
    input logic [IdxWidth-1:0] idx
  );
    logic [31:0] low;
    low = 32'(idx);
    return {soc_pkg::RomTag, low};
  endfunction

  logic [soc_pkg::DataWidth-1:0] word;

  assign word = rom_word(idx_i);

  // Output holds its value between requests
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= word;
    end
  end

endmodule

// File: mem/data_sram.sv
// Byte-enabled data SRAM with registered reads and the simulation exit register
module data_sram #(
  parameter int unsigned SramWords = 256
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [$clog2(SramWords)-1:0]  idx_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  input  logic [soc_pkg::BeWidth-1:0]   be_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic [31:0]                   exit_o
);

  localparam int unsigned IdxWidth = $clog2(SramWords);
  localparam int unsigned ExitIdx  = soc_pkg::ExitOffset / soc_pkg::BeWidth;

  logic [soc_pkg::DataWidth-1:0] mem_q [SramWords];
  logic                          exit_hit;
  logic [31:0]                   exit_q;

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < soc_pkg::BeWidth; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

  // ----------------------------------------
  // Exit register
  // ----------------------------------------
  // Any byte enable counts, the low word is taken as a whole
  assign exit_hit = req_i & we_i & (|be_i) & (idx_i == IdxWidth'(ExitIdx));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q <= '0;
    end else if (exit_hit) begin
      exit_q <= wdata_i[31:0];
    end
  end

  assign exit_o = exit_q;

endmodule

// File: mini_soc.f
+incdir+tb
common/soc_pkg.sv
hw/bus_arbiter.sv
hw/periph_mux.sv
hw/debug_req_gate.sv
mem/boot_rom.sv
mem/data_sram.sv
hw/soc_top.sv
tb/tb_soc_top.sv

// File: tb/tb_soc_tasks.svh
// Bus request tasks for both master ports and the reference model, included by the testbench top

// ----------------------------------------
// Reference model
// ----------------------------------------
logic [63:0] model_mem [SramWords];
logic [31:0] model_exit;

// Address falls inside the SRAM region
function automatic bit in_sram(input logic [31:0] addr);
  return (addr >= soc_pkg::SramBase) && ((addr - soc_pkg::SramBase) < SramWords * 8);
endfunction

// Expected {err, rdata} of one access under the address map
function automatic logic [64:0] ref_response(input logic we, input logic [31:0] addr);
  logic [31:0] rom_off;
  rom_off = addr - soc_pkg::RomBase;
  if (addr >= soc_pkg::RomBase && rom_off < soc_pkg::RomLength && !we) begin
    return {1'b0, soc_pkg::RomTag, rom_off >> 3};
  end
  if (in_sram(addr)) begin
    if (we) begin
      return 65'd0;
    end
    return {1'b0, model_mem[(addr - soc_pkg::SramBase) >> 3]};
  end
  return {1'b1, 64'd0};
endfunction

// Byte merge into the model, exit word tracked alongside
task automatic model_update(input logic we, input logic [31:0] addr,
                            input logic [63:0] wdata, input logic [7:0] be);
  logic [31:0] idx;
  idx = (addr - soc_pkg::SramBase) >> 3;
  if (we && in_sram(addr)) begin
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    if (idx == (soc_pkg::ExitOffset >> 3) && (|be)) begin
      model_exit = wdata[31:0];
    end
  end
endtask

// ----------------------------------------
// Master port requests
// ----------------------------------------
// Called on a falling edge, returns on the falling edge that shows rvalid
task automatic core_access(input logic we, input logic [31:0] addr,
                           input logic [63:0] wdata, input logic [7:0] be);
  int unsigned cnt;
  core_req_i   = 1'b1;
  core_we_i    = we;
  core_addr_i  = addr;
  core_wdata_i = wdata;
  core_be_i    = be;
  cnt = 0;
  #1;
  while (!core_gnt_o) begin
    @(negedge clk_i);
    #1;
    cnt++;
    if (cnt > WaitLimit) begin
      report_timeout("a grant on the core port");
    end
  end
  core_exp_q.push_back(ref_response(we, addr));
  model_update(we, addr, wdata, be);
  @(negedge clk_i);
  core_req_i = 1'b0;
  cnt = 0;
  while (!core_rvalid_o) begin
    @(negedge clk_i);
    cnt++;
    if (cnt > WaitLimit) begin
      report_timeout("rvalid on the core port");
    end
  end
endtask

task automatic dbg_access(input logic we, input logic [31:0] addr,
                          input logic [63:0] wdata, input logic [7:0] be);
  int unsigned cnt;
  dbg_req_i   = 1'b1;
  dbg_we_i    = we;
  dbg_addr_i  = addr;
  dbg_wdata_i = wdata;
  dbg_be_i    = be;
  cnt = 0;
  #1;
  while (!dbg_gnt_o) begin
    @(negedge clk_i);
    #1;
    cnt++;
    if (cnt > WaitLimit) begin
      report_timeout("a grant on the debug port");
    end
  end
  dbg_exp_q.push_back(ref_response(we, addr));
  model_update(we, addr, wdata, be);
  @(negedge clk_i);
  dbg_req_i = 1'b0;
  cnt = 0;
  while (!dbg_rvalid_o) begin
    @(negedge clk_i);
    cnt++;
    if (cnt > WaitLimit) begin
      report_timeout("rvalid on the debug port");
    end
  end
endtask

// File: tb/tb_soc_top.sv
// Testbench for soc_top that drives both bus masters and the debug inputs and checks every response
module tb_soc_top;

  localparam int unsigned SramWords  = 256;
  localparam int unsigned DebugDelay = 40;
  localparam int unsigned WaitLimit  = 100;

  logic        clk_i;
  logic        rst_ni;
  logic        core_req_i;
  logic        core_we_i;
  logic [31:0] core_addr_i;
  logic [63:0] core_wdata_i;
  logic [7:0]  core_be_i;
  logic        core_gnt_o;
  logic        core_rvalid_o;
  logic [63:0] core_rdata_o;
  logic        core_err_o;
  logic        dbg_req_i;
  logic        dbg_we_i;
  logic [31:0] dbg_addr_i;
  logic [63:0] dbg_wdata_i;
  logic [7:0]  dbg_be_i;
  logic        dbg_gnt_o;
  logic        dbg_rvalid_o;
  logic [63:0] dbg_rdata_o;
  logic        dbg_err_o;
  logic        debug_req_i;
  logic        debug_en_i;
  logic        debug_req_o;
  logic [31:0] exit_o;

  integer           seed;
  int unsigned      n_errors;
  int unsigned      n_checks;
  logic [64:0]      core_exp_q [$];
  logic [64:0]      dbg_exp_q [$];
  soc_pkg::master_e last_gnt;
  logic             core_gnt_prev;
  logic             dbg_gnt_prev;

  soc_top #(
    .SramWords  ( SramWords  ),
    .DebugDelay ( DebugDelay )
  ) i_dut (
    .clk_i, .rst_ni,
    .core_req_i, .core_we_i, .core_addr_i, .core_wdata_i, .core_be_i,
    .core_gnt_o, .core_rvalid_o, .core_rdata_o, .core_err_o,
    .dbg_req_i, .dbg_we_i, .dbg_addr_i, .dbg_wdata_i, .dbg_be_i,
    .dbg_gnt_o, .dbg_rvalid_o, .dbg_rdata_o, .dbg_err_o,
    .debug_req_i, .debug_en_i, .debug_req_o, .exit_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  `include "tb_soc_tasks.svh"

  // One random ROM, SRAM or unmapped access from either port
  task automatic random_access(input bit on_dbg);
    logic [31:0] sel;
    logic [31:0] r;
    logic        we;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  be;
    sel   = $random(seed);
    r     = $random(seed);
    wdata = {$random(seed), $random(seed)};
    be    = r[15:8];
    we    = r[16];
    case (sel[1:0])
      2'd0: begin
        we   = 1'b0;
        addr = soc_pkg::RomBase + {25'd0, r[3:0], 3'd0};
      end
      2'd3:    addr = 32'h2000_0000 + {21'd0, r[7:0], 3'd0};
      default: addr = soc_pkg::SramBase + {21'd0, r[7:0], 3'd0};
    endcase
    if (on_dbg) begin
      dbg_access(we, addr, wdata, be);
    end else begin
      core_access(we, addr, wdata, be);
    end
  endtask

  // ----------------------------------------
  // Response checker and grant monitor
  // ----------------------------------------
  always begin : compare_responses
    logic [64:0] exp_rsp;
    @(negedge clk_i);
    #2;
    if (core_gnt_o && dbg_gnt_o) begin
      n_errors++;
      $display("error at %0t: both ports granted in one cycle", $time);
    end
    // A tie goes to the port that was not granted last
    if (core_req_i && dbg_req_i) begin
      n_checks++;
      if ((last_gnt == soc_pkg::MST_CORE) ? !dbg_gnt_o : !core_gnt_o) begin
        n_errors++;
        $display("error at %0t: grants did not alternate", $time);
      end
    end
    if (core_gnt_o) begin
      last_gnt = soc_pkg::MST_CORE;
    end else if (dbg_gnt_o) begin
      last_gnt = soc_pkg::MST_DEBUG;
    end
    // Response comes exactly one cycle after the grant
    if (core_rvalid_o !== core_gnt_prev || dbg_rvalid_o !== dbg_gnt_prev) begin
      n_errors++;
      $display("error at %0t: rvalid not one cycle after the grant", $time);
    end
    core_gnt_prev = core_gnt_o;
    dbg_gnt_prev  = dbg_gnt_o;
    if (core_rvalid_o) begin
      if (core_exp_q.size() == 0) begin
        n_errors++;
        $display("error at %0t: rvalid on the core port without a request", $time);
      end else begin
        exp_rsp = core_exp_q.pop_front();
        n_checks++;
        if ({core_err_o, core_rdata_o} !== exp_rsp) begin
          n_errors++;
          $display("error at %0t: core response %h, expected %h", $time,
                   {core_err_o, core_rdata_o}, exp_rsp);
        end
      end
    end
    if (dbg_rvalid_o) begin
      if (dbg_exp_q.size() == 0) begin
        n_errors++;
        $display("error at %0t: rvalid on the debug port without a request", $time);
      end else begin
        exp_rsp = dbg_exp_q.pop_front();
        n_checks++;
        if ({dbg_err_o, dbg_rdata_o} !== exp_rsp) begin
          n_errors++;
          $display("error at %0t: debug response %h, expected %h", $time,
                   {dbg_err_o, dbg_rdata_o}, exp_rsp);
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [31:0] r;
    seed          = 32'hc196_934c;
    n_errors      = 0;
    n_checks      = 0;
    last_gnt      = soc_pkg::MST_DEBUG;
    core_gnt_prev = 1'b0;
    dbg_gnt_prev  = 1'b0;
    rst_ni        = 1'b0;
    core_req_i    = 1'b0;
    core_we_i     = 1'b0;
    core_addr_i   = '0;
    core_wdata_i  = '0;
    core_be_i     = '0;
    dbg_req_i     = 1'b0;
    dbg_we_i      = 1'b0;
    dbg_addr_i    = '0;
    dbg_wdata_i   = '0;
    dbg_be_i      = '0;
    debug_req_i   = 1'b1;
    debug_en_i    = 1'b1;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    n_checks++;
    if (exit_o !== 32'd0) begin
      n_errors++;
      $display("error at %0t: exit_o is %h after reset", $time, exit_o);
    end

    // Debug hold-off where cycle k is the falling edge after the k-th rising edge
    for (int k = 1; k <= 50; k++) begin
      @(negedge clk_i);
      if (k <= 35 || k >= 45) begin
        n_checks++;
        if (debug_req_o !== (k >= 45)) begin
          n_errors++;
          $display("error at %0t: debug_req_o is %b in cycle %0d", $time, debug_req_o, k);
        end
      end
    end
    debug_en_i = 1'b0;
    #1;
    n_checks++;
    if (debug_req_o !== 1'b0) begin
      n_errors++;
      $display("error at %0t: debug_req_o still high with debug disabled", $time);
    end
    @(negedge clk_i);

    // ROM reads and a write to ROM
    for (int i = 0; i < 16; i++) begin
      core_access(1'b0, soc_pkg::RomBase + 32'(i * 8), '0, 8'hff);
    end
    core_access(1'b1, soc_pkg::RomBase + 32'h8, 64'h1234_5678_9abc_def0, 8'hff);

    // Fill the SRAM with an address-derived pattern
    for (int i = 0; i < SramWords; i++) begin
      addr = soc_pkg::SramBase + 32'(i * 8);
      core_access(1'b1, addr, {~addr, addr}, 8'hff);
    end

    // Byte-enabled writes read back from both ports
    for (int i = 0; i < 32; i++) begin
      r     = $random(seed);
      addr  = soc_pkg::SramBase + {21'd0, r[7:0], 3'd0};
      wdata = {$random(seed), $random(seed)};
      core_access(1'b1, addr, wdata, r[15:8]);
      dbg_access(1'b0, addr, '0, 8'hff);
      core_access(1'b0, addr, '0, 8'hff);
    end

    // Unmapped writes past the SRAM end and in an empty region before a read of the aliased word
    core_access(1'b1, soc_pkg::SramBase + 32'(SramWords * 8 + 40), 64'hdead_beef, 8'hff);
    core_access(1'b1, 32'h4000_0000, 64'hfeed_f00d, 8'hff);
    dbg_access(1'b0, soc_pkg::SramBase + 32'd40, '0, 8'hff);

    // Both ports at once
    fork
      begin
        for (int i = 0; i < 100; i++) begin
          random_access(1'b0);
        end
      end
      begin
        for (int i = 0; i < 100; i++) begin
          random_access(1'b1);
        end
      end
    join

    // Exit register
    wdata = {$random(seed), $random(seed)};
    core_access(1'b1, soc_pkg::SramBase + soc_pkg::ExitOffset, wdata, 8'hff);
    @(negedge clk_i);
    n_checks++;
    if (exit_o !== model_exit) begin
      n_errors++;
      $display("error at %0t: exit_o is %h, expected %h", $time, exit_o, model_exit);
    end
    dbg_access(1'b0, soc_pkg::SramBase + soc_pkg::ExitOffset, '0, 8'hff);

    @(negedge clk_i);
    #3;
    if (core_exp_q.size() != 0 || dbg_exp_q.size() != 0) begin
      n_errors++;
      $display("Responses missing at the end, core %0d, debug %0d",
               core_exp_q.size(), dbg_exp_q.size());
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
